/* compile.f */
ex_pkg.sv
ex_alu.sv
ex_branch.sv
ex_ctrl.sv
ex_stage.sv
ex_subsystem.sv
tb_ex_subsystem.sv

/* Makefile */
# Verilator build and run of the execute stage subsystem testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_ex_subsystem
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_ex_subsystem.sv */
// Directed testbench for the execute stage subsystem
// Plays the decode and write-back sides, models the ALU and the write-back
// filters, and checks retired results, redirects, halt and kill
`timescale 1ns/1ps

module tb_ex_subsystem
  import ex_pkg::*;
();

  localparam int CLK_PERIOD    = 100;
  localparam int BOOT_TIMEOUT  = 8;
  localparam int ISSUE_TIMEOUT = 20;
  localparam int DRAIN_TIMEOUT = 40;

  // One entry per instruction that must reach write-back
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] result;
    logic            rf_we;
    logic            csr_en;
    int              accept;
    bit              chk_lat;
  } exp_t;

  logic            clk;
  logic            rst_n_i;
  logic            id_valid_i;
  logic            id_ready_o;
  logic [XLEN-1:0] pc_i;
  alu_op_e         alu_op_i;
  logic [XLEN-1:0] op_a_i;
  logic [XLEN-1:0] op_b_i;
  logic [XLEN-1:0] imm_i;
  logic            branch_i;
  logic            compressed_i;
  logic            rf_we_i;
  logic            csr_en_i;
  logic            xif_en_i;
  logic            lsu_en_i;
  logic            lsu_split_i;
  logic            wb_valid_o;
  logic            wb_ready_i;
  logic [XLEN-1:0] wb_pc_o;
  logic [XLEN-1:0] wb_result_o;
  logic            wb_rf_we_o;
  logic            wb_csr_en_o;
  logic            csr_illegal_i;
  logic            dataindtiming_i;
  logic            halt_req_i;
  logic            kill_req_i;
  logic            pc_set_o;
  pc_mux_e         pc_mux_o;
  logic [XLEN-1:0] branch_target_o;
  logic            kill_if_o;
  logic            kill_id_o;

  exp_t            exp_q[$];
  int              seed;
  int              cycle_cnt;
  logic [XLEN-1:0] next_pc;
  alu_op_e         alu_ops [6] = '{ADD, SUB, AND, OR, XOR, SLT};

  ex_subsystem uut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // Counts rising edges, used to measure the EX to WB latency
  initial begin
    cycle_cnt = 0;
    forever begin
      @(posedge clk);
      cycle_cnt++;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and typed compares
  //////////////////////////////////////////////////////////////////////

  task automatic stop_on_failure();
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic timeout_failure(input string what);
    $display("Timeout at %0t: no progress while waiting for %s", $time, what);
    stop_on_failure();
  endtask

  task automatic compare_word(input string what, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic compare_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic compare_pc_mux(input string what, input pc_mux_e got, input pc_mux_e exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
      stop_on_failure();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model and stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // Branch opcodes leave the data result at zero
  function automatic logic [XLEN-1:0] model_alu(input alu_op_e op, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    logic [XLEN-1:0] res;
    logic            lt;
    res = '0;
    // Different signs decide by the sign of a, equal signs by magnitude
    lt = (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : (a < b);
    case (op)
      ADD:     res = a + b;
      SUB:     res = a - b;
      AND:     res = a & b;
      OR:      res = a | b;
      XOR:     res = a ^ b;
      SLT:     res[0] = lt;
      default: res = '0;
    endcase
    return res;
  endfunction

  task automatic set_alu(input alu_op_e op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    pc_i         = next_pc;
    next_pc      = next_pc + 32'd4;
    alu_op_i     = op;
    op_a_i       = a;
    op_b_i       = b;
    imm_i        = '0;
    branch_i     = 1'b0;
    compressed_i = 1'b0;
    rf_we_i      = 1'b1;
    csr_en_i     = 1'b0;
    xif_en_i     = 1'b0;
    lsu_en_i     = 1'b0;
    lsu_split_i  = 1'b0;
  endtask

  task automatic set_branch(input alu_op_e op, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b, input logic [XLEN-1:0] imm,
                            input logic compressed);
    set_alu(op, a, b);
    imm_i        = imm;
    branch_i     = 1'b1;
    compressed_i = compressed;
    rf_we_i      = 1'b0;
    if (compressed) begin
      next_pc = pc_i + 32'd2;
    end
  endtask

  // Presents the instruction from a falling edge and holds it until the
  // DUT takes it, then returns on the next falling edge with valid low
  task automatic issue(input bit expect_retire, input bit chk_lat);
    exp_t e;
    int   waited;
    waited     = 0;
    id_valid_i = 1'b1;
    #1;
    while (!(id_ready_o && !kill_id_o)) begin
      if (waited == ISSUE_TIMEOUT) timeout_failure("the DUT to accept an instruction");
      @(negedge clk);
      #1;
      waited++;
    end
    if (expect_retire) begin
      e.pc      = pc_i;
      e.result  = model_alu(alu_op_i, op_a_i, op_b_i);
      // A legal CSR that the coprocessor did not take is the only one kept
      e.csr_en  = csr_en_i && !xif_en_i && !csr_illegal_i;
      e.rf_we   = rf_we_i && !(lsu_en_i && lsu_split_i) && !(csr_en_i && csr_illegal_i);
      e.accept  = cycle_cnt;
      e.chk_lat = chk_lat;
      exp_q.push_back(e);
    end
    @(negedge clk);
    id_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 || wb_valid_o) begin
      if (waited == DRAIN_TIMEOUT) timeout_failure("the pipeline to drain");
      @(negedge clk);
      waited++;
    end
  endtask

  task automatic check_redirect(input pc_mux_e mux, input logic [XLEN-1:0] addr);
    compare_bit("pc_set_o", pc_set_o, 1'b1);
    compare_pc_mux("pc_mux_o", pc_mux_o, mux);
    compare_word("branch_target_o", branch_target_o, addr);
    compare_bit("kill_if_o", kill_if_o, 1'b1);
    compare_bit("kill_id_o", kill_id_o, 1'b1);
  endtask

  task automatic check_no_redirect();
    compare_bit("pc_set_o", pc_set_o, 1'b0);
    compare_bit("kill_if_o", kill_if_o, 1'b0);
    compare_bit("kill_id_o", kill_id_o, 1'b0);
  endtask

  // Sampled mid low phase, where every input of the next edge is settled
  initial begin : retire_monitor
    exp_t e;
    forever begin
      @(negedge clk);
      #5;
      if (rst_n_i && wb_valid_o && wb_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Unexpected result retired at %0t for pc %h", $time, wb_pc_o);
          stop_on_failure();
        end else begin
          e = exp_q.pop_front();
          compare_word("wb_pc_o", wb_pc_o, e.pc);
          compare_word("wb_result_o", wb_result_o, e.result);
          compare_bit("wb_rf_we_o", wb_rf_we_o, e.rf_we);
          compare_bit("wb_csr_en_o", wb_csr_en_o, e.csr_en);
          if (e.chk_lat) begin
            compare_word("retire latency", XLEN'(cycle_cnt - e.accept), XLEN'(2));
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_boot_and_alu();
    int              waited;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    waited = 0;
    while (!pc_set_o) begin
      if (waited == BOOT_TIMEOUT) timeout_failure("the boot redirect");
      @(negedge clk);
      waited++;
    end
    compare_pc_mux("pc_mux_o at boot", pc_mux_o, PC_BOOT);
    compare_word("boot redirect address", branch_target_o, BOOT_ADDR);
    // The boot redirect lasts a single cycle
    repeat (3) begin
      @(negedge clk);
      compare_bit("pc_set_o after boot", pc_set_o, 1'b0);
    end
    for (int i = 0; i < 12; i++) begin
      a = $random(seed);
      b = $random(seed);
      set_alu(alu_ops[i % 6], a, b);
      issue(1'b1, 1'b1);
    end
    wait_drain();
  endtask

  task automatic test_backpressure();
    wb_ready_i = 1'b0;
    set_alu(ADD, $random(seed), $random(seed));
    issue(1'b1, 1'b0);
    set_alu(XOR, $random(seed), $random(seed));
    issue(1'b1, 1'b0);
    // WB and EX are both full now, a third instruction has to wait
    set_alu(SUB, $random(seed), $random(seed));
    id_valid_i = 1'b1;
    repeat (4) begin
      #1;
      compare_bit("id_ready_o under back-pressure", id_ready_o, 1'b0);
      compare_bit("wb_valid_o under back-pressure", wb_valid_o, 1'b1);
      compare_word("held wb_pc_o", wb_pc_o, exp_q[0].pc);
      compare_word("held wb_result_o", wb_result_o, exp_q[0].result);
      @(negedge clk);
    end
    wb_ready_i = 1'b1;
    issue(1'b1, 1'b0);
    wait_drain();
  endtask

  task automatic test_csr_suppression();
    for (int i = 0; i < 4; i++) begin
      set_alu(ADD, $random(seed), $random(seed));
      csr_en_i      = 1'b1;
      xif_en_i      = i[1];
      csr_illegal_i = i[0];
      issue(1'b1, 1'b0);
      wait_drain();
    end
    csr_illegal_i = 1'b0;
    // First half of a split access, then an ordinary access
    set_alu(ADD, $random(seed), $random(seed));
    lsu_en_i    = 1'b1;
    lsu_split_i = 1'b1;
    issue(1'b1, 1'b0);
    set_alu(ADD, $random(seed), $random(seed));
    lsu_en_i = 1'b1;
    issue(1'b1, 1'b0);
    wait_drain();
  endtask

  task automatic test_branches();
    logic [XLEN-1:0] bpc;
    set_branch(BEQ, 32'h1234_5678, 32'h1234_5678, 32'h0000_0040, 1'b0);
    bpc = pc_i;
    issue(1'b1, 1'b0);
    // The next instruction is already offered while the branch resolves
    set_alu(ADD, $random(seed), $random(seed));
    id_valid_i = 1'b1;
    #1;
    check_redirect(PC_BRANCH, bpc + 32'h0000_0040);
    @(negedge clk);
    id_valid_i = 1'b0;
    #1;
    compare_bit("pc_set_o after branch", pc_set_o, 1'b0);
    @(negedge clk);
    wait_drain();

    set_branch(BNE, 32'h0000_0007, 32'h0000_0007, 32'h0000_0100, 1'b0);
    issue(1'b1, 1'b0);
    #1;
    check_no_redirect();
    @(negedge clk);
    wait_drain();

    // Untaken branches redirect to the next sequential pc
    dataindtiming_i = 1'b1;
    set_branch(BNE, 32'h0000_0003, 32'h0000_0003, 32'h0000_0200, 1'b1);
    bpc = pc_i;
    issue(1'b1, 1'b0);
    #1;
    check_redirect(PC_BRANCH, bpc + 32'd2);
    @(negedge clk);
    wait_drain();
    set_branch(BEQ, 32'h0000_0003, 32'h0000_0004, 32'h0000_0200, 1'b0);
    bpc = pc_i;
    issue(1'b1, 1'b0);
    #1;
    check_redirect(PC_BRANCH, bpc + 32'd4);
    @(negedge clk);
    wait_drain();
    dataindtiming_i = 1'b0;
  endtask

  task automatic test_halt_kill();
    set_alu(OR, $random(seed), $random(seed));
    issue(1'b1, 1'b0);
    halt_req_i = 1'b1;
    set_alu(AND, $random(seed), $random(seed));
    id_valid_i = 1'b1;
    repeat (4) begin
      #1;
      compare_bit("id_ready_o during halt", id_ready_o, 1'b0);
      compare_bit("wb_valid_o during halt", wb_valid_o, 1'b0);
      @(negedge clk);
    end
    halt_req_i = 1'b0;
    issue(1'b1, 1'b0);
    wait_drain();

    // The killed instruction gets no expectation, so a retire fails
    set_alu(SUB, $random(seed), $random(seed));
    issue(1'b0, 1'b0);
    // Halt is raised as well, so only the kill can make EX ready
    halt_req_i = 1'b1;
    kill_req_i = 1'b1;
    #1;
    check_redirect(PC_TRAP, TRAP_ADDR);
    compare_bit("id_ready_o during kill", id_ready_o, 1'b1);
    @(negedge clk);
    halt_req_i = 1'b0;
    kill_req_i = 1'b0;
    repeat (4) begin
      @(negedge clk);
      compare_bit("wb_valid_o after kill", wb_valid_o, 1'b0);
    end
  endtask

  initial begin
    seed            = 32'h48ac;
    next_pc         = 32'h0000_1000;
    rst_n_i         = 1'b0;
    id_valid_i      = 1'b0;
    pc_i            = '0;
    alu_op_i        = ADD;
    op_a_i          = '0;
    op_b_i          = '0;
    imm_i           = '0;
    branch_i        = 1'b0;
    compressed_i    = 1'b0;
    rf_we_i         = 1'b0;
    csr_en_i        = 1'b0;
    xif_en_i        = 1'b0;
    lsu_en_i        = 1'b0;
    lsu_split_i     = 1'b0;
    wb_ready_i      = 1'b1;
    csr_illegal_i   = 1'b0;
    dataindtiming_i = 1'b0;
    halt_req_i      = 1'b0;
    kill_req_i      = 1'b0;
    repeat (4) begin
      @(negedge clk);
      check_no_redirect();
      compare_bit("wb_valid_o in reset", wb_valid_o, 1'b0);
    end
    rst_n_i = 1'b1;
    test_boot_and_alu();
    test_backpressure();
    test_csr_suppression();
    test_branches();
    test_halt_kill();
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* ex_subsystem.sv */
// Execute stage subsystem top level
// Connects the EX pipeline, the ALU, the branch unit and the controller
// slice that steers PC redirects and the halt and kill of the stages
`timescale 1ns/1ps

module ex_subsystem
  import ex_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            id_valid_i,
  output logic            id_ready_o,
  input  logic [XLEN-1:0] pc_i,
  input  alu_op_e         alu_op_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic            branch_i,
  input  logic            compressed_i,
  input  logic            rf_we_i,
  input  logic            csr_en_i,
  input  logic            xif_en_i,
  input  logic            lsu_en_i,
  input  logic            lsu_split_i,
  output logic            wb_valid_o,
  input  logic            wb_ready_i,
  output logic [XLEN-1:0] wb_pc_o,
  output logic [XLEN-1:0] wb_result_o,
  output logic            wb_rf_we_o,
  output logic            wb_csr_en_o,
  input  logic            csr_illegal_i,
  input  logic            dataindtiming_i,
  input  logic            halt_req_i,
  input  logic            kill_req_i,
  output logic            pc_set_o,
  output pc_mux_e         pc_mux_o,
  output logic [XLEN-1:0] branch_target_o,
  output logic            kill_if_o,
  output logic            kill_id_o
);

  logic            halt_ex;
  logic            kill_ex;
  logic [XLEN-1:0] ex_pc;
  alu_op_e         ex_alu_op;
  logic [XLEN-1:0] ex_op_a;
  logic [XLEN-1:0] ex_op_b;
  logic [XLEN-1:0] ex_imm;
  logic            ex_compressed;
  logic            ex_branch_first;
  logic [XLEN-1:0] alu_result;
  logic            alu_cmp_result;
  logic            branch_taken;
  logic [XLEN-1:0] branch_target;

  ex_stage u_ex_stage (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .id_valid_i        (id_valid_i),
    .id_ready_o        (id_ready_o),
    .pc_i              (pc_i),
    .alu_op_i          (alu_op_i),
    .op_a_i            (op_a_i),
    .op_b_i            (op_b_i),
    .imm_i             (imm_i),
    .branch_i          (branch_i),
    .compressed_i      (compressed_i),
    .rf_we_i           (rf_we_i),
    .csr_en_i          (csr_en_i),
    .xif_en_i          (xif_en_i),
    .lsu_en_i          (lsu_en_i),
    .lsu_split_i       (lsu_split_i),
    .wb_ready_i        (wb_ready_i),
    .csr_illegal_i     (csr_illegal_i),
    .halt_ex_i         (halt_ex),
    .kill_ex_i         (kill_ex),
    .kill_id_i         (kill_id_o),
    .dataindtiming_i   (dataindtiming_i),
    .alu_result_i      (alu_result),
    .ex_pc_o           (ex_pc),
    .ex_alu_op_o       (ex_alu_op),
    .ex_op_a_o         (ex_op_a),
    .ex_op_b_o         (ex_op_b),
    .ex_imm_o          (ex_imm),
    .ex_compressed_o   (ex_compressed),
    .ex_branch_first_o (ex_branch_first),
    .wb_valid_o        (wb_valid_o),
    .wb_pc_o           (wb_pc_o),
    .wb_result_o       (wb_result_o),
    .wb_rf_we_o        (wb_rf_we_o),
    .wb_csr_en_o       (wb_csr_en_o)
  );

  ex_alu u_ex_alu (
    .alu_op_i     (ex_alu_op),
    .op_a_i       (ex_op_a),
    .op_b_i       (ex_op_b),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  // Only the first EX cycle of a branch is presented as a branch
  ex_branch u_ex_branch (
    .branch_i        (ex_branch_first),
    .cmp_result_i    (alu_cmp_result),
    .dataindtiming_i (dataindtiming_i),
    .compressed_i    (ex_compressed),
    .pc_i            (ex_pc),
    .imm_i           (ex_imm),
    .taken_o         (branch_taken),
    .target_o        (branch_target)
  );

  ex_ctrl u_ex_ctrl (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .halt_req_i      (halt_req_i),
    .kill_req_i      (kill_req_i),
    .branch_first_i  (ex_branch_first),
    .branch_taken_i  (branch_taken),
    .branch_target_i (branch_target),
    .halt_ex_o       (halt_ex),
    .kill_ex_o       (kill_ex),
    .pc_set_o        (pc_set_o),
    .pc_mux_o        (pc_mux_o),
    .redirect_addr_o (branch_target_o),
    .kill_if_o       (kill_if_o),
    .kill_id_o       (kill_id_o)
  );

endmodule

/* ex_stage.sv */
// Execute stage pipeline registers and handshakes
// Holds the instruction in EX and the result register towards write-back,
// obeys halt and kill, and filters CSR and register write enables
`timescale 1ns/1ps

module ex_stage
  import ex_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            id_valid_i,
  output logic            id_ready_o,
  input  logic [XLEN-1:0] pc_i,
  input  alu_op_e         alu_op_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic            branch_i,
  input  logic            compressed_i,
  input  logic            rf_we_i,
  input  logic            csr_en_i,
  input  logic            xif_en_i,
  input  logic            lsu_en_i,
  input  logic            lsu_split_i,
  input  logic            wb_ready_i,
  input  logic            csr_illegal_i,
  input  logic            halt_ex_i,
  input  logic            kill_ex_i,
  input  logic            kill_id_i,
  input  logic            dataindtiming_i,
  input  logic [XLEN-1:0] alu_result_i,
  output logic [XLEN-1:0] ex_pc_o,
  output alu_op_e         ex_alu_op_o,
  output logic [XLEN-1:0] ex_op_a_o,
  output logic [XLEN-1:0] ex_op_b_o,
  output logic [XLEN-1:0] ex_imm_o,
  output logic            ex_compressed_o,
  output logic            ex_branch_first_o,
  output logic            wb_valid_o,
  output logic [XLEN-1:0] wb_pc_o,
  output logic [XLEN-1:0] wb_result_o,
  output logic            wb_rf_we_o,
  output logic            wb_csr_en_o
);

  logic ex_valid_q;
  logic ex_branch_q;
  logic ex_rf_we_q;
  logic ex_csr_en_q;
  logic ex_xif_en_q;
  logic ex_lsu_en_q;
  logic ex_lsu_split_q;
  // Marks that the branch in EX already had its redirect cycle
  logic branch_seen_q;
  logic ex_valid;
  logic ex_move;
  logic id_transfer;

  // EX offers its instruction unless halted or killed
  assign ex_valid    = ex_valid_q && !halt_ex_i && !kill_ex_i;
  // It moves on when the WB register is empty or retires this edge
  assign ex_move     = ex_valid && (!wb_valid_o || wb_ready_i);
  assign id_ready_o  = kill_ex_i || (!halt_ex_i && (!ex_valid_q || ex_move));
  // A killed decode stage never hands its instruction over
  assign id_transfer = id_valid_i && id_ready_o && !kill_id_i;

  assign ex_branch_first_o = ex_valid_q && ex_branch_q && !branch_seen_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_valid_q    <= 1'b0;
      branch_seen_q <= 1'b0;
      wb_valid_o    <= 1'b0;
    end else begin
      if (id_transfer) begin
        ex_valid_q <= 1'b1;
      end else if (kill_ex_i || ex_move) begin
        ex_valid_q <= 1'b0;
      end
      // A new or departing instruction starts with a clean flag
      if (id_transfer || kill_ex_i || ex_move) begin
        branch_seen_q <= 1'b0;
      end else if (ex_branch_first_o) begin
        branch_seen_q <= 1'b1;
      end
      if (ex_move) begin
        wb_valid_o <= 1'b1;
      end else if (wb_ready_i) begin
        wb_valid_o <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Payload registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (id_transfer) begin
      ex_pc_o         <= pc_i;
      ex_alu_op_o     <= alu_op_i;
      ex_op_a_o       <= op_a_i;
      ex_op_b_o       <= op_b_i;
      ex_imm_o        <= imm_i;
      ex_compressed_o <= compressed_i;
      ex_branch_q     <= branch_i;
      ex_rf_we_q      <= rf_we_i;
      ex_csr_en_q     <= csr_en_i;
      ex_xif_en_q     <= xif_en_i;
      ex_lsu_en_q     <= lsu_en_i;
      ex_lsu_split_q  <= lsu_split_i;
    end
    if (ex_move) begin
      wb_pc_o     <= ex_pc_o;
      wb_result_o <= alu_result_i;
      // The coprocessor owns CSRs it accepted, illegal ones are dropped
      wb_csr_en_o <= ex_csr_en_q && !ex_xif_en_q && !csr_illegal_i;
      // First half of a split access and illegal CSRs write nothing
      wb_rf_we_o  <= ex_rf_we_q && !(ex_lsu_en_q && ex_lsu_split_q) &&
                     !(ex_csr_en_q && csr_illegal_i);
    end
  end

  property p_csr_filter(logic xif, logic illegal, logic exp_csr);
    @(posedge clk) disable iff (!rst_n_i)
      (ex_move && ex_csr_en_q && (ex_xif_en_q == xif) && (csr_illegal_i == illegal))
      |=> (wb_csr_en_o == exp_csr);
  endproperty

  // Halt from the controller stops both handshakes of this stage
  a_halt : assert property (@(posedge clk) disable iff (!rst_n_i)
                            (halt_ex_i && !kill_ex_i) |-> (!id_ready_o && !ex_valid));
  a_kill : assert property (@(posedge clk) disable iff (!rst_n_i)
                            kill_ex_i |-> (id_ready_o && !ex_valid));
  // Only a legal CSR that the coprocessor did not take reaches WB
  a_csr_xif_legal     : assert property (p_csr_filter(1'b1, 1'b0, 1'b0));
  a_csr_xif_illegal   : assert property (p_csr_filter(1'b1, 1'b1, 1'b0));
  a_csr_pipe_illegal  : assert property (p_csr_filter(1'b0, 1'b1, 1'b0));
  a_csr_pipe_legal    : assert property (p_csr_filter(1'b0, 1'b0, 1'b1));
  a_split_rf_we : assert property (@(posedge clk) disable iff (!rst_n_i)
                                   (ex_move && ex_lsu_en_q && ex_lsu_split_q) |=> !wb_rf_we_o);
  // The branch decision depends on this mode while the branch sits in EX
  a_dit_stable : assert property (@(posedge clk) disable iff (!rst_n_i)
                                  (ex_valid_q && !ex_move && !kill_ex_i)
                                  |=> $stable(dataindtiming_i));

endmodule

/* ex_ctrl.sv */
// Pipeline controller slice for the execute stage
// Sends the boot redirect, passes halt and kill requests to EX, and
// turns a taken branch into a PC redirect that flushes fetch and decode
`timescale 1ns/1ps

module ex_ctrl
  import ex_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            halt_req_i,
  input  logic            kill_req_i,
  input  logic            branch_first_i,
  input  logic            branch_taken_i,
  input  logic [XLEN-1:0] branch_target_i,
  output logic            halt_ex_o,
  output logic            kill_ex_o,
  output logic            pc_set_o,
  output pc_mux_e         pc_mux_o,
  output logic [XLEN-1:0] redirect_addr_o,
  output logic            kill_if_o,
  output logic            kill_id_o
);

  ctrl_state_e state_q;

  // Set at the first edge after reset, so the boot redirect is not
  // visible while reset is still asserted
  logic out_of_reset_q;

  logic boot_cycle;
  logic branch_redirect;

  assign boot_cycle      = (state_q == BOOT) && out_of_reset_q;
  assign branch_redirect = branch_first_i && branch_taken_i;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q        <= BOOT;
      out_of_reset_q <= 1'b0;
    end else begin
      out_of_reset_q <= 1'b1;
      // Leave BOOT once the boot redirect has been issued
      if (boot_cycle) begin
        state_q <= RUN;
      end
    end
  end

  // Halt and kill reach EX in the same cycle
  assign halt_ex_o = halt_req_i;
  assign kill_ex_o = kill_req_i;

  // Younger instructions in fetch and decode are wrong path on a kill
  // or a taken branch
  assign kill_if_o = kill_req_i || branch_redirect;
  assign kill_id_o = kill_req_i || branch_redirect;

  //////////////////////////////////////////////////////////////////////
  // Redirect priority, boot first, then kill, then branch
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    pc_set_o        = 1'b0;
    pc_mux_o        = PC_BRANCH;
    redirect_addr_o = branch_target_i;
    if (boot_cycle) begin
      pc_set_o        = 1'b1;
      pc_mux_o        = PC_BOOT;
      redirect_addr_o = BOOT_ADDR;
    end else if (kill_req_i) begin
      pc_set_o        = 1'b1;
      pc_mux_o        = PC_TRAP;
      redirect_addr_o = TRAP_ADDR;
    end else if (branch_redirect) begin
      pc_set_o = 1'b1;
    end
  end

  // Every branch redirect flushes the stages behind EX
  a_branch_kills_if_id :
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     (pc_set_o && (pc_mux_o == PC_BRANCH)) |-> (kill_if_o && kill_id_o));

  // The branch unit reports every branch as taken under data independent
  // timing, so each first branch cycle in RUN must set the PC
  a_branch_first_sets_pc :
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     (branch_first_i && branch_taken_i && (state_q == RUN) && !kill_req_i)
                     |-> (pc_set_o && (pc_mux_o == PC_BRANCH)));

  // EX drops its instruction on a kill and then reports ready, which is
  // only safe when decode is flushed in the same cycle
  a_kill_ex_consistent :
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     (kill_ex_o && !boot_cycle)
                     |-> (kill_id_o && kill_if_o && pc_set_o && (pc_mux_o == PC_TRAP)));

endmodule

/* ex_branch.sv */
// Branch decision and target calculation
// A branch is taken when its compare holds, or always when data
// independent timing is on, in which case an untaken branch redirects
// to the next sequential instruction
`timescale 1ns/1ps

module ex_branch
  import ex_pkg::*;
(
  input  logic            branch_i,
  input  logic            cmp_result_i,
  input  logic            dataindtiming_i,
  input  logic            compressed_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] imm_i,
  output logic            taken_o,
  output logic [XLEN-1:0] target_o
);

  // Step to the next sequential instruction
  logic [XLEN-1:0] seq_step;

  // Next sequential pc, used as target when the compare fails
  logic [XLEN-1:0] seq_pc;

  assign seq_step = compressed_i ? XLEN'(2) : XLEN'(4);
  assign seq_pc   = pc_i + seq_step;

  // With data independent timing every branch redirects, so taken and
  // untaken branches cost the same number of cycles
  assign taken_o = branch_i && (cmp_result_i || dataindtiming_i);

  // The real target when the compare holds, else the fall-through pc
  assign target_o = cmp_result_i ? (pc_i + imm_i) : seq_pc;

  // A forced redirect of an untaken branch must land on the instruction
  // right after the branch, 2 or 4 bytes on depending on its size
  always_comb begin
    a_dit_fall_through :
      assert final (!(branch_i && dataindtiming_i && !cmp_result_i) ||
                    (target_o == pc_i + (compressed_i ? XLEN'(2) : XLEN'(4))))
        else $error("ex_branch: wrong fall-through target for untaken branch");
  end

endmodule

/* ex_alu.sv */
// Execute stage ALU
// Computes add, subtract, logic and signed set-less-than results, and
// the equality compare that the branch unit uses for BEQ and BNE
`timescale 1ns/1ps

module ex_alu
  import ex_pkg::*;
(
  input  alu_op_e         alu_op_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,
  output logic [XLEN-1:0] result_o,
  output logic            cmp_result_o
);

  // Signed compare for SLT
  logic signed_lt;

  // Equality of both operands, shared by BEQ and BNE
  logic ops_equal;

  assign signed_lt = $signed(op_a_i) < $signed(op_b_i);
  assign ops_equal = (op_a_i == op_b_i);

  //////////////////////////////////////////////////////////////////////
  // Operation select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    result_o     = '0;
    cmp_result_o = 1'b0;
    case (alu_op_i)
      ADD: result_o = op_a_i + op_b_i;
      SUB: result_o = op_a_i - op_b_i;
      AND: result_o = op_a_i & op_b_i;
      OR:  result_o = op_a_i | op_b_i;
      XOR: result_o = op_a_i ^ op_b_i;
      // Only the lowest bit carries the compare, the rest stays zero
      SLT: result_o = {{(XLEN-1){1'b0}}, signed_lt};
      // Branches produce no data result, only the compare flag
      BEQ: cmp_result_o = ops_equal;
      BNE: cmp_result_o = !ops_equal;
      default: begin
        result_o     = '0;
        cmp_result_o = 1'b0;
      end
    endcase
  end

  // The branch unit takes cmp_result as branch condition without looking
  // at the opcode, so it must never be high for a plain ALU operation
  always_comb begin
    a_cmp_only_on_branch :
      assert final ((alu_op_i inside {BEQ, BNE}) || !cmp_result_o)
        else $error("ex_alu: compare result high for a non-branch opcode");
  end

endmodule

/* ex_pkg.sv */
// Shared definitions of the execute stage subsystem
// Holds the ALU opcodes, the redirect sources, the controller states,
// the data width and the fixed redirect addresses
package ex_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and fixed addresses
  //////////////////////////////////////////////////////////////////////

  // Data and address width of the whole pipeline
  localparam int unsigned XLEN = 32;

  // Fetch restarts here once reset has been released
  localparam logic [XLEN-1:0] BOOT_ADDR = 32'h0000_0080;

  // Fetch restarts here when the controller kills the EX stage
  localparam logic [XLEN-1:0] TRAP_ADDR = 32'h0000_0100;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // ALU operations, the two branch opcodes only drive the compare result
  typedef enum logic [3:0] {
    ADD = 4'h0,
    SUB = 4'h1,
    AND = 4'h2,
    OR  = 4'h3,
    XOR = 4'h4,
    SLT = 4'h5,
    BEQ = 4'h8,
    BNE = 4'h9
  } alu_op_e;

  // Source of a program counter redirect
  typedef enum logic [1:0] {
    PC_BOOT   = 2'b00,
    PC_BRANCH = 2'b01,
    PC_TRAP   = 2'b10
  } pc_mux_e;

  // Controller state, BOOT only lasts until the boot redirect went out
  typedef enum logic {
    BOOT = 1'b0,
    RUN  = 1'b1
  } ctrl_state_e;

endpackage
